// ==== Makefile ====
# Verilator flow for the ID stage testbench

VERILATOR ?= verilator
TOP       ?= id_stage_tb
RTL_TOP   ?= id_stage
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --timing --timescale $(TIMESCALE)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/id_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb import mips_isa_pkg::*; import id_ctrl_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int MAX_VECS   = 64;
    localparam int VEC_W      = 412;

    // check mask bits
    localparam int CHK_STAGE  = 0;
    localparam int CHK_DECODE = 1;
    localparam int CHK_RDATA1 = 2;
    localparam int CHK_RDATA2 = 3;
    localparam int CHK_BRANCH = 4;
    localparam int CHK_STALL  = 5;

    logic      clk;
    logic      rst;
    logic      stall_if;
    logic      stall_id;
    logic      if_valid;
    word_t     if_pc;
    word_t     inst_sram_rdata;
    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;
    logic      ex_fwd_we;
    reg_addr_t ex_fwd_waddr;
    word_t     ex_fwd_wdata;
    logic      ex_fwd_is_load;
    logic      mem_fwd_we;
    reg_addr_t mem_fwd_waddr;
    word_t     mem_fwd_wdata;

    logic      ex_valid;
    word_t     ex_pc;
    word_t     ex_inst;
    alu_op_t   ex_alu_op;
    src1_sel_t ex_src1_sel;
    src2_sel_t ex_src2_sel;
    logic      ex_mem_en;
    byte_en_t  ex_mem_wen;
    logic      ex_rf_we;
    reg_addr_t ex_rf_waddr;
    logic      ex_sel_load;
    word_t     ex_rdata1;
    word_t     ex_rdata2;
    logic      br_taken;
    word_t     br_target;
    logic      stallreq;

    logic [VEC_W-1:0] vecs [MAX_VECS];
    int               num_vectors;
    int               error_count;
    logic             vectors_ready;

    ////////////////////
    // fields of the current vector
    logic [3:0]  v_ctl;
    word_t       v_pc;
    word_t       v_inst;
    logic [3:0]  v_wb_flag;
    logic [7:0]  v_wb_addr;
    word_t       v_wb_data;
    logic [3:0]  v_ex_flag;
    logic [7:0]  v_ex_addr;
    word_t       v_ex_data;
    logic [3:0]  v_mem_flag;
    logic [7:0]  v_mem_addr;
    word_t       v_mem_data;
    logic [7:0]  v_mask;
    logic [3:0]  v_valid;
    word_t       v_exp_pc;
    word_t       v_exp_inst;
    logic [11:0] v_alu;
    logic [3:0]  v_src1;
    logic [3:0]  v_src2;
    logic [3:0]  v_mem_flags;
    logic [3:0]  v_wen;
    logic [7:0]  v_waddr;
    word_t       v_rdata1;
    word_t       v_rdata2;
    logic [3:0]  v_br_flags;
    word_t       v_target;

    id_stage dut0 (
        .clk(clk), .rst(rst), .stall_if(stall_if), .stall_id(stall_id),
        .if_valid(if_valid), .if_pc(if_pc), .inst_sram_rdata(inst_sram_rdata),
        .wb_we(wb_we), .wb_waddr(wb_waddr), .wb_wdata(wb_wdata),
        .ex_fwd_we(ex_fwd_we), .ex_fwd_waddr(ex_fwd_waddr), .ex_fwd_wdata(ex_fwd_wdata),
        .ex_fwd_is_load(ex_fwd_is_load),
        .mem_fwd_we(mem_fwd_we), .mem_fwd_waddr(mem_fwd_waddr),
        .mem_fwd_wdata(mem_fwd_wdata),
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_inst(ex_inst), .ex_alu_op(ex_alu_op),
        .ex_src1_sel(ex_src1_sel), .ex_src2_sel(ex_src2_sel), .ex_mem_en(ex_mem_en),
        .ex_mem_wen(ex_mem_wen), .ex_rf_we(ex_rf_we), .ex_rf_waddr(ex_rf_waddr),
        .ex_sel_load(ex_sel_load), .ex_rdata1(ex_rdata1), .ex_rdata2(ex_rdata2),
        .br_taken(br_taken), .br_target(br_target), .stallreq(stallreq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input int idx, input string name, input word_t got,
                                   input word_t exp);
        error_count++;
        $display("ERROR %0t: vector %0d %s is %h, expected %h", $time, idx, name, got, exp);
    endtask

    // split a vector into fields and put the inputs on the DUT
    task automatic drive_vector(input int idx);
        {v_ctl, v_pc, v_inst, v_wb_flag, v_wb_addr, v_wb_data, v_ex_flag, v_ex_addr,
         v_ex_data, v_mem_flag, v_mem_addr, v_mem_data, v_mask, v_valid, v_exp_pc,
         v_exp_inst, v_alu, v_src1, v_src2, v_mem_flags, v_wen, v_waddr, v_rdata1,
         v_rdata2, v_br_flags, v_target} = vecs[6'(idx)];
        {rst, stall_if, stall_id, if_valid} = v_ctl;
        if_pc           = v_pc;
        inst_sram_rdata = v_inst;
        wb_we           = v_wb_flag[0];
        wb_waddr        = v_wb_addr[4:0];
        wb_wdata        = v_wb_data;
        ex_fwd_we       = v_ex_flag[0];
        ex_fwd_is_load  = v_ex_flag[1];
        ex_fwd_waddr    = v_ex_addr[4:0];
        ex_fwd_wdata    = v_ex_data;
        mem_fwd_we      = v_mem_flag[0];
        mem_fwd_waddr   = v_mem_addr[4:0];
        mem_fwd_wdata   = v_mem_data;
    endtask

    task automatic check_outputs(input int idx);
        if (v_mask[CHK_STAGE]) begin
            if (ex_valid !== v_valid[0])
                report_mismatch(idx, "ex_valid", 32'(ex_valid), 32'(v_valid[0]));
            if (ex_pc !== v_exp_pc)
                report_mismatch(idx, "ex_pc", ex_pc, v_exp_pc);
            if (ex_inst !== v_exp_inst)
                report_mismatch(idx, "ex_inst", ex_inst, v_exp_inst);
        end
        if (v_mask[CHK_DECODE]) begin
            if (ex_alu_op !== v_alu)
                report_mismatch(idx, "ex_alu_op", 32'(ex_alu_op), 32'(v_alu));
            if (ex_src1_sel !== v_src1[2:0])
                report_mismatch(idx, "ex_src1_sel", 32'(ex_src1_sel), 32'(v_src1[2:0]));
            if (ex_src2_sel !== v_src2)
                report_mismatch(idx, "ex_src2_sel", 32'(ex_src2_sel), 32'(v_src2));
            if (ex_mem_en !== v_mem_flags[2])
                report_mismatch(idx, "ex_mem_en", 32'(ex_mem_en), 32'(v_mem_flags[2]));
            if (ex_rf_we !== v_mem_flags[1])
                report_mismatch(idx, "ex_rf_we", 32'(ex_rf_we), 32'(v_mem_flags[1]));
            if (ex_sel_load !== v_mem_flags[0])
                report_mismatch(idx, "ex_sel_load", 32'(ex_sel_load), 32'(v_mem_flags[0]));
            if (ex_mem_wen !== v_wen)
                report_mismatch(idx, "ex_mem_wen", 32'(ex_mem_wen), 32'(v_wen));
            if (ex_rf_waddr !== v_waddr[4:0])
                report_mismatch(idx, "ex_rf_waddr", 32'(ex_rf_waddr), 32'(v_waddr[4:0]));
        end
        if (v_mask[CHK_RDATA1] && ex_rdata1 !== v_rdata1)
            report_mismatch(idx, "ex_rdata1", ex_rdata1, v_rdata1);
        if (v_mask[CHK_RDATA2] && ex_rdata2 !== v_rdata2)
            report_mismatch(idx, "ex_rdata2", ex_rdata2, v_rdata2);
        if (v_mask[CHK_BRANCH]) begin
            if (br_taken !== v_br_flags[1])
                report_mismatch(idx, "br_taken", 32'(br_taken), 32'(v_br_flags[1]));
            if (br_target !== v_target)
                report_mismatch(idx, "br_target", br_target, v_target);
        end
        if (v_mask[CHK_STALL] && stallreq !== v_br_flags[0])
            report_mismatch(idx, "stallreq", 32'(stallreq), 32'(v_br_flags[0]));
    endtask

    ////////////////////
    // main sequence
    initial begin
        rst             = 1'b1;
        stall_if        = 1'b0;
        stall_id        = 1'b0;
        if_valid        = 1'b0;
        if_pc           = '0;
        inst_sram_rdata = '0;
        wb_we           = 1'b0;
        wb_waddr        = '0;
        wb_wdata        = '0;
        ex_fwd_we       = 1'b0;
        ex_fwd_waddr    = '0;
        ex_fwd_wdata    = '0;
        ex_fwd_is_load  = 1'b0;
        mem_fwd_we      = 1'b0;
        mem_fwd_waddr   = '0;
        mem_fwd_wdata   = '0;
        error_count     = 0;
        num_vectors     = 0;
        vectors_ready   = 1'b0;

        // all ones marks an empty slot
        for (int i = 0; i < MAX_VECS; i++) begin
            vecs[i] = '1;
        end
        $readmemh("dv/id_stim.txt", vecs);
        while (num_vectors < MAX_VECS && vecs[6'(num_vectors)] != '1) begin
            num_vectors++;
        end
        vectors_ready = 1'b1;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < num_vectors; i++) begin
            drive_vector(i);
            #2.5;
            check_outputs(i);
            @(posedge clk);
            #1;
        end

        $display("vectors: %0d  errors: %0d", num_vectors, error_count);
        if (num_vectors > 0 && error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (vectors_ready);
        #((num_vectors + 10) * CLK_PERIOD);
        $display("timeout: the vector run did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/id_stim.txt ====
// ctl{rst,stall_if,stall_id,if_valid} if_pc inst | wb{we} addr data | ex{load,we} addr data | mem{we} addr data
// mask | valid pc inst | alu src1 src2 {mem_en,rf_we,sel_load} wen waddr | rdata1 rdata2 | {taken,stallreq} target
1_00001000_00221821_1_01_00000010_0_00_00000000_0_00_00000000_03_0_00000000_00221821_800_1_1_2_0_03_00000000_00000000_0_00000000
1_00001004_342400ff_1_02_fffffff0_0_00_00000000_0_00_00000000_07_1_00001000_342400ff_020_1_8_2_0_04_00000010_00000000_0_00000000
1_00001008_00221821_1_00_deadbeef_0_00_00000000_0_00_00000000_0f_1_00001004_00221821_800_1_1_2_0_03_00000010_fffffff0_0_00000000
1_0000100c_3c051234_0_00_00000000_0_00_00000000_0_00_00000000_07_1_00001008_3c051234_001_0_2_2_0_05_00000000_00000000_0_00000000
1_00001010_000230c0_0_00_00000000_0_00_00000000_0_00_00000000_0f_1_0000100c_000230c0_008_4_1_2_0_06_00000000_fffffff0_0_00000000
1_00001014_0022382a_0_00_00000000_0_00_00000000_0_00_00000000_0f_1_00001010_0022382a_200_1_1_2_0_07_00000010_fffffff0_0_00000000
1_00001018_8c280004_0_00_00000000_3_03_00000000_0_00_00000000_23_1_00001014_8c280004_800_1_2_7_0_08_00000000_00000000_0_00000000
1_0000101c_ac220008_0_00_00000000_3_02_00000000_0_00_00000000_23_1_00001018_ac220008_800_1_2_4_f_00_00000000_00000000_1_00000000
1_00001020_01221821_1_09_cccc0001_1_09_aaaa0001_1_09_bbbb0001_2c_0_00000000_00000000_000_0_0_0_0_00_aaaa0001_fffffff0_0_00000000
1_00001024_01221821_1_09_cccc0001_0_00_00000000_1_09_bbbb0001_04_0_00000000_00000000_000_0_0_0_0_00_bbbb0001_00000000_0_00000000
1_00001028_01221821_1_09_cccc0002_0_00_00000000_0_00_00000000_04_0_00000000_00000000_000_0_0_0_0_00_cccc0002_00000000_0_00000000
1_0000102c_10220004_0_00_00000000_0_00_00000000_0_00_00000000_10_0_00000000_00000000_000_0_0_0_0_00_00000000_00000000_0_0000103c
1_00001030_10220004_0_00_00000000_1_02_00000010_0_00_00000000_10_0_00000000_00000000_000_0_0_0_0_00_00000000_00000000_2_00001040
1_00001034_14220004_0_00_00000000_0_00_00000000_0_00_00000000_10_0_00000000_00000000_000_0_0_0_0_00_00000000_00000000_2_00001044
1_00001038_04210004_0_00_00000000_0_00_00000000_0_00_00000000_10_0_00000000_00000000_000_0_0_0_0_00_00000000_00000000_2_00001048
1_0000103c_0430fffe_0_00_00000000_0_00_00000000_0_00_00000000_12_0_00000000_00000000_800_2_4_2_0_1f_00000000_00000000_0_00001034
1_00001040_0430fffe_0_00_00000000_0_00_00000000_1_01_80000000_10_0_00000000_00000000_000_0_0_0_0_00_00000000_00000000_2_00001038
1_00001044_08100040_0_00_00000000_0_00_00000000_0_00_00000000_10_0_00000000_00000000_000_0_0_0_0_00_00000000_00000000_2_00400100
1_00001048_0c000080_0_00_00000000_0_00_00000000_0_00_00000000_12_0_00000000_00000000_800_2_4_2_0_1f_00000000_00000000_2_00000200
1_0000104c_00400008_0_00_00000000_0_00_00000000_0_00_00000000_10_0_00000000_00000000_000_0_0_0_0_00_00000000_00000000_2_fffffff0
5_00001050_00221821_0_00_00000000_0_00_00000000_0_00_00000000_01_1_0000104c_00221821_000_0_0_0_0_00_00000000_00000000_0_00000000
1_00001054_342400ff_0_00_00000000_0_00_00000000_0_00_00000000_01_0_00000000_342400ff_000_0_0_0_0_00_00000000_00000000_0_00000000
7_00001058_3c051234_0_00_00000000_0_00_00000000_0_00_00000000_01_1_00001054_3c051234_000_0_0_0_0_00_00000000_00000000_0_00000000
7_0000105c_000230c0_0_00_00000000_0_00_00000000_0_00_00000000_01_1_00001054_3c051234_000_0_0_0_0_00_00000000_00000000_0_00000000
1_00001060_000230c0_0_00_00000000_0_00_00000000_0_00_00000000_01_1_00001054_3c051234_000_0_0_0_0_00_00000000_00000000_0_00000000
1_00001064_0022382a_0_00_00000000_0_00_00000000_0_00_00000000_01_1_00001060_0022382a_000_0_0_0_0_00_00000000_00000000_0_00000000

// ==== files.f ====
hw/mips_isa_pkg.sv
hw/id_ctrl_pkg.sv
hw/id_stage_reg.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/operand_bypass.sv
hw/branch_unit.sv
hw/id_stage.sv
dv/id_stage_tb.sv

// ==== hw/branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit import mips_isa_pkg::*; import id_ctrl_pkg::*; (
    input  word_t       pc,
    input  word_t       inst,
    input  logic [11:0] br_kind,
    input  word_t       rdata1,
    input  word_t       rdata2,
    output logic        br_taken,
    output word_t       br_target
);

    imm_t  offset;
    jidx_t jidx;
    word_t pc_plus4;
    word_t rel_target;
    word_t jump_target;
    logic  rs_eq_rt;
    logic  rs_ge_z;
    logic  rs_gt_z;
    logic  rs_le_z;
    logic  rs_lt_z;
    logic  rel_kind;

    assign offset = inst[IMM_W-1:0];
    assign jidx   = inst[JIDX_W-1:0];

    ////////////////////
    // targets
    assign pc_plus4    = pc + 32'd4;
    assign rel_target  = pc_plus4 + {{(WORD_W-IMM_W-2){offset[IMM_W-1]}}, offset, 2'b00};
    // region jump keeps the top nibble of the delay slot pc
    assign jump_target = {pc_plus4[WORD_W-1 -: 4], jidx, 2'b00};

    // conditions on the bypassed operands
    assign rs_eq_rt = (rdata1 == rdata2);
    assign rs_lt_z  = rdata1[WORD_W-1];
    assign rs_ge_z  = !rs_lt_z;
    assign rs_gt_z  = rs_ge_z && (rdata1 != '0);
    assign rs_le_z  = !rs_gt_z;

    assign rel_kind = br_kind[BR_BEQ] | br_kind[BR_BNE] | br_kind[BR_BGEZ]
                    | br_kind[BR_BGTZ] | br_kind[BR_BLEZ] | br_kind[BR_BLTZ]
                    | br_kind[BR_BGEZAL] | br_kind[BR_BLTZAL];

    assign br_taken = (br_kind[BR_BEQ] & rs_eq_rt)
                    | (br_kind[BR_BNE] & !rs_eq_rt)
                    | ((br_kind[BR_BGEZ] | br_kind[BR_BGEZAL]) & rs_ge_z)
                    | ((br_kind[BR_BLTZ] | br_kind[BR_BLTZAL]) & rs_lt_z)
                    | (br_kind[BR_BGTZ] & rs_gt_z)
                    | (br_kind[BR_BLEZ] & rs_le_z)
                    | br_kind[BR_J] | br_kind[BR_JAL]
                    | br_kind[BR_JR] | br_kind[BR_JALR];

    always_comb begin
        if (rel_kind) begin
            br_target = rel_target;
        end else if (br_kind[BR_J] || br_kind[BR_JAL]) begin
            br_target = jump_target;
        end else if (br_kind[BR_JR] || br_kind[BR_JALR]) begin
            br_target = rdata1;
        end else begin
            br_target = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/id_ctrl_pkg.sv ====
`default_nettype none

package id_ctrl_pkg;

    typedef logic [11:0] alu_op_t;
    typedef logic [2:0]  src1_sel_t;
    typedef logic [3:0]  src2_sel_t;
    typedef logic [3:0]  byte_en_t;

    ////////////////////
    // one-hot alu operation bits, add on top
    localparam int ALU_ADD  = 11;
    localparam int ALU_SUB  = 10;
    localparam int ALU_SLT  = 9;
    localparam int ALU_SLTU = 8;
    localparam int ALU_AND  = 7;
    localparam int ALU_NOR  = 6;
    localparam int ALU_OR   = 5;
    localparam int ALU_XOR  = 4;
    localparam int ALU_SLL  = 3;
    localparam int ALU_SRL  = 2;
    localparam int ALU_SRA  = 1;
    localparam int ALU_LUI  = 0;

    // first operand select bits
    localparam int SRC1_RS = 0;
    localparam int SRC1_PC = 1;
    localparam int SRC1_SA = 2;

    // second operand select bits
    localparam int SRC2_RT   = 0;
    localparam int SRC2_SIMM = 1;
    localparam int SRC2_LINK = 2;
    localparam int SRC2_ZIMM = 3;

    ////////////////////
    // one-hot branch kind bits
    localparam int BR_BEQ    = 11;
    localparam int BR_BNE    = 10;
    localparam int BR_BGEZ   = 9;
    localparam int BR_BGTZ   = 8;
    localparam int BR_BLEZ   = 7;
    localparam int BR_BLTZ   = 6;
    localparam int BR_BGEZAL = 5;
    localparam int BR_BLTZAL = 4;
    localparam int BR_J      = 3;
    localparam int BR_JAL    = 2;
    localparam int BR_JR     = 1;
    localparam int BR_JALR   = 0;

endpackage

`default_nettype wire

// ==== hw/id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage import mips_isa_pkg::*; import id_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      stall_if,
    input  logic      stall_id,
    input  logic      if_valid,
    input  word_t     if_pc,
    input  word_t     inst_sram_rdata,
    input  logic      wb_we,
    input  reg_addr_t wb_waddr,
    input  word_t     wb_wdata,
    input  logic      ex_fwd_we,
    input  reg_addr_t ex_fwd_waddr,
    input  word_t     ex_fwd_wdata,
    input  logic      ex_fwd_is_load,
    input  logic      mem_fwd_we,
    input  reg_addr_t mem_fwd_waddr,
    input  word_t     mem_fwd_wdata,
    output logic      ex_valid,
    output word_t     ex_pc,
    output word_t     ex_inst,
    output alu_op_t   ex_alu_op,
    output src1_sel_t ex_src1_sel,
    output src2_sel_t ex_src2_sel,
    output logic      ex_mem_en,
    output byte_en_t  ex_mem_wen,
    output logic      ex_rf_we,
    output reg_addr_t ex_rf_waddr,
    output logic      ex_sel_load,
    output word_t     ex_rdata1,
    output word_t     ex_rdata2,
    output logic      br_taken,
    output word_t     br_target,
    output logic      stallreq
);

    reg_addr_t   rs;
    reg_addr_t   rt;
    word_t       file_rdata1;
    word_t       file_rdata2;
    logic [11:0] br_kind;

    assign rs = ex_inst[RS_LSB +: REG_ADDR_W];
    assign rt = ex_inst[RT_LSB +: REG_ADDR_W];

    id_stage_reg u_stage_reg (
        .clk(clk), .rst(rst), .stall_if(stall_if), .stall_id(stall_id),
        .if_valid(if_valid), .if_pc(if_pc), .inst_sram_rdata(inst_sram_rdata),
        .id_valid(ex_valid), .id_pc(ex_pc), .id_inst(ex_inst)
    );

    inst_decoder u_decoder (
        .inst(ex_inst), .alu_op(ex_alu_op), .src1_sel(ex_src1_sel),
        .src2_sel(ex_src2_sel), .mem_en(ex_mem_en), .sel_load(ex_sel_load),
        .rf_we(ex_rf_we), .mem_wen(ex_mem_wen), .rf_waddr(ex_rf_waddr),
        .br_kind(br_kind)
    );

    regfile u_regfile (
        .clk(clk), .raddr1(rs), .raddr2(rt), .rdata1(file_rdata1), .rdata2(file_rdata2),
        .we(wb_we), .waddr(wb_waddr), .wdata(wb_wdata)
    );

    operand_bypass u_bypass (
        .rs(rs), .rt(rt), .file_rdata1(file_rdata1), .file_rdata2(file_rdata2),
        .ex_fwd_we(ex_fwd_we), .ex_fwd_waddr(ex_fwd_waddr), .ex_fwd_wdata(ex_fwd_wdata),
        .ex_fwd_is_load(ex_fwd_is_load),
        .mem_fwd_we(mem_fwd_we), .mem_fwd_waddr(mem_fwd_waddr),
        .mem_fwd_wdata(mem_fwd_wdata),
        .wb_we(wb_we), .wb_waddr(wb_waddr), .wb_wdata(wb_wdata),
        .rdata1(ex_rdata1), .rdata2(ex_rdata2), .stallreq(stallreq)
    );

    branch_unit u_branch (
        .pc(ex_pc), .inst(ex_inst), .br_kind(br_kind),
        .rdata1(ex_rdata1), .rdata2(ex_rdata2),
        .br_taken(br_taken), .br_target(br_target)
    );

endmodule

`default_nettype wire

// ==== hw/id_stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage_reg import mips_isa_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  stall_if,
    input  logic  stall_id,
    input  logic  if_valid,
    input  word_t if_pc,
    input  word_t inst_sram_rdata,
    output logic  id_valid,
    output word_t id_pc,
    output word_t id_inst
);

    logic  hold_flag;
    word_t hold_inst;

    // IF/ID register
    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid  <= 1'b0;
            id_pc     <= '0;
            hold_flag <= 1'b0;
        end else if (stall_if && !stall_id) begin
            // fetch stalled alone, push a bubble
            id_valid  <= 1'b0;
            id_pc     <= '0;
            hold_flag <= 1'b0;
        end else if (!stall_if) begin
            id_valid  <= if_valid;
            id_pc     <= if_pc;
            hold_flag <= 1'b0;
        end else if (stall_id) begin
            hold_flag <= 1'b1;
        end
    end

    // track the sram word until decode stalls
    always_ff @(posedge clk) begin
        if (!hold_flag) begin
            hold_inst <= inst_sram_rdata;
        end
    end

    // sram data arrives a cycle late, so it is the live word
    assign id_inst = hold_flag ? hold_inst : inst_sram_rdata;

endmodule

`default_nettype wire

// ==== hw/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import mips_isa_pkg::*; import id_ctrl_pkg::*; (
    input  word_t      inst,
    output alu_op_t    alu_op,
    output src1_sel_t  src1_sel,
    output src2_sel_t  src2_sel,
    output logic       mem_en,
    output logic       sel_load,
    output logic       rf_we,
    output byte_en_t   mem_wen,
    output reg_addr_t  rf_waddr,
    output logic [11:0] br_kind
);

    opcode_t   op;
    funct_t    fn;
    reg_addr_t rt;
    reg_addr_t rd;
    logic      special;
    logic      regimm;
    logic      r_rd;
    logic      shift_sa;
    logic      i_sext;
    logic      i_zext;
    logic      i_lui;
    logic      i_lw;
    logic      i_sw;
    logic      to_ra;
    logic      link;

    assign op = inst[OP_LSB +: OPCODE_W];
    assign fn = inst[FUNCT_W-1:0];
    assign rt = inst[RT_LSB +: REG_ADDR_W];
    assign rd = inst[RD_LSB +: REG_ADDR_W];

    assign special = (op == OP_SPECIAL);
    assign regimm  = (op == OP_REGIMM);

    ////////////////////
    // instruction groups
    assign shift_sa = special && (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA);
    // R-type writing rd from two registers
    assign r_rd = special && (fn == FN_ADD || fn == FN_ADDU || fn == FN_SUB
                  || fn == FN_SUBU || fn == FN_AND || fn == FN_OR || fn == FN_XOR
                  || fn == FN_NOR || fn == FN_SLT || fn == FN_SLTU
                  || fn == FN_SLLV || fn == FN_SRLV || fn == FN_SRAV);
    assign i_sext = (op == OP_ADDI || op == OP_ADDIU || op == OP_SLTI || op == OP_SLTIU);
    assign i_zext = (op == OP_ANDI || op == OP_ORI || op == OP_XORI);
    assign i_lui  = (op == OP_LUI);
    assign i_lw   = (op == OP_LW);
    assign i_sw   = (op == OP_SW);

    always_comb begin
        br_kind = '0;
        br_kind[BR_BEQ]    = (op == OP_BEQ);
        br_kind[BR_BNE]    = (op == OP_BNE);
        br_kind[BR_BGEZ]   = regimm && (rt == RT_BGEZ);
        br_kind[BR_BGTZ]   = (op == OP_BGTZ) && (rt == '0);
        br_kind[BR_BLEZ]   = (op == OP_BLEZ) && (rt == '0);
        br_kind[BR_BLTZ]   = regimm && (rt == RT_BLTZ);
        br_kind[BR_BGEZAL] = regimm && (rt == RT_BGEZAL);
        br_kind[BR_BLTZAL] = regimm && (rt == RT_BLTZAL);
        br_kind[BR_J]      = (op == OP_J);
        br_kind[BR_JAL]    = (op == OP_JAL);
        br_kind[BR_JR]     = special && (fn == FN_JR);
        br_kind[BR_JALR]   = special && (fn == FN_JALR);
    end

    // jal and the regimm links go to ra, jalr to rd
    assign to_ra = br_kind[BR_JAL] | br_kind[BR_BGEZAL] | br_kind[BR_BLTZAL];
    assign link  = to_ra | br_kind[BR_JALR];

    ////////////////////
    // operand selects and alu op
    always_comb begin
        src1_sel = '0;
        src1_sel[SRC1_RS] = r_rd | i_sext | i_zext | i_lw | i_sw;
        src1_sel[SRC1_PC] = link;
        src1_sel[SRC1_SA] = shift_sa;

        src2_sel = '0;
        src2_sel[SRC2_RT]   = r_rd | shift_sa;
        src2_sel[SRC2_SIMM] = i_sext | i_lui | i_lw | i_sw;
        src2_sel[SRC2_LINK] = link;
        src2_sel[SRC2_ZIMM] = i_zext;

        alu_op = '0;
        alu_op[ALU_ADD]  = (special && (fn == FN_ADD || fn == FN_ADDU))
                           || op == OP_ADDI || op == OP_ADDIU || i_lw || i_sw || link;
        alu_op[ALU_SUB]  = special && (fn == FN_SUB || fn == FN_SUBU);
        alu_op[ALU_SLT]  = (special && fn == FN_SLT) || op == OP_SLTI;
        alu_op[ALU_SLTU] = (special && fn == FN_SLTU) || op == OP_SLTIU;
        alu_op[ALU_AND]  = (special && fn == FN_AND) || op == OP_ANDI;
        alu_op[ALU_NOR]  = special && fn == FN_NOR;
        alu_op[ALU_OR]   = (special && fn == FN_OR) || op == OP_ORI;
        alu_op[ALU_XOR]  = (special && fn == FN_XOR) || op == OP_XORI;
        alu_op[ALU_SLL]  = special && (fn == FN_SLL || fn == FN_SLLV);
        alu_op[ALU_SRL]  = special && (fn == FN_SRL || fn == FN_SRLV);
        alu_op[ALU_SRA]  = special && (fn == FN_SRA || fn == FN_SRAV);
        alu_op[ALU_LUI]  = i_lui;
    end

    // memory and write-back control
    assign mem_en   = i_lw | i_sw;
    assign mem_wen  = i_sw ? 4'b1111 : 4'b0000;
    assign sel_load = i_lw;
    assign rf_we    = r_rd | shift_sa | i_sext | i_zext | i_lui | i_lw | link;

    always_comb begin
        if (to_ra) begin
            rf_waddr = RA_REG;
        end else if (r_rd || shift_sa || br_kind[BR_JALR]) begin
            rf_waddr = rd;
        end else if (i_sext || i_zext || i_lui || i_lw) begin
            rf_waddr = rt;
        end else begin
            rf_waddr = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

    // instruction format widths
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int IMM_W      = 16;
    localparam int JIDX_W     = 26;
    localparam int NUM_REGS   = 32;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [OPCODE_W-1:0]   opcode_t;
    typedef logic [FUNCT_W-1:0]    funct_t;
    typedef logic [IMM_W-1:0]      imm_t;
    typedef logic [JIDX_W-1:0]     jidx_t;

    // field lsb positions
    localparam int OP_LSB = 26;
    localparam int RS_LSB = 21;
    localparam int RT_LSB = 16;
    localparam int RD_LSB = 11;

    ////////////////////
    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_REGIMM  = 6'h01;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_BLEZ    = 6'h06;
    localparam opcode_t OP_BGTZ    = 6'h07;
    localparam opcode_t OP_ADDI    = 6'h08;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_SLTIU   = 6'h0b;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    ////////////////////
    // SPECIAL function codes
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_SLLV = 6'h04;
    localparam funct_t FN_SRLV = 6'h06;
    localparam funct_t FN_SRAV = 6'h07;
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_JALR = 6'h09;
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;

    // REGIMM codes in the rt field
    localparam reg_addr_t RT_BLTZ   = 5'h00;
    localparam reg_addr_t RT_BGEZ   = 5'h01;
    localparam reg_addr_t RT_BLTZAL = 5'h10;
    localparam reg_addr_t RT_BGEZAL = 5'h11;

    // link register and return address distance from the branch
    localparam reg_addr_t RA_REG      = 5'd31;
    localparam word_t     LINK_OFFSET = 32'd8;

endpackage

`default_nettype wire

// ==== hw/operand_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_bypass import mips_isa_pkg::*; (
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  word_t     file_rdata1,
    input  word_t     file_rdata2,
    input  logic      ex_fwd_we,
    input  reg_addr_t ex_fwd_waddr,
    input  word_t     ex_fwd_wdata,
    input  logic      ex_fwd_is_load,
    input  logic      mem_fwd_we,
    input  reg_addr_t mem_fwd_waddr,
    input  word_t     mem_fwd_wdata,
    input  logic      wb_we,
    input  reg_addr_t wb_waddr,
    input  word_t     wb_wdata,
    output word_t     rdata1,
    output word_t     rdata2,
    output logic      stallreq
);

    // youngest producer first, r0 stays with the file
    function automatic word_t bypass_pick(input reg_addr_t addr, input word_t file_data);
        word_t data;
        data = file_data;
        if (addr != '0) begin
            if (ex_fwd_we && ex_fwd_waddr == addr) begin
                data = ex_fwd_wdata;
            end else if (mem_fwd_we && mem_fwd_waddr == addr) begin
                data = mem_fwd_wdata;
            end else if (wb_we && wb_waddr == addr) begin
                data = wb_wdata;
            end
        end
        return data;
    endfunction

    always_comb begin
        rdata1 = bypass_pick(rs, file_rdata1);
        rdata2 = bypass_pick(rt, file_rdata2);
    end

    // load data is not ready until MEM
    assign stallreq = ex_fwd_is_load && (ex_fwd_waddr == rs || ex_fwd_waddr == rt);

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile import mips_isa_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    word_t regs [NUM_REGS];

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // old value on a same-cycle write, WB bypass is outside
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire
